// File: compile.f
+incdir+include
rtl/CpuPkg.sv
rtl/CpuIfs.sv
rtl/MainDecoder.sv
rtl/RegFile.sv
rtl/Alu.sv
rtl/InstructionMemory.sv
rtl/DataMemory.sv
rtl/NextPcUnit.sv
rtl/SingleCycleCpu.sv
verif/SingleCycleCpuTb.sv

// File: Bender.yml
package:
  name: single_cycle_cpu

export_include_dirs:
  - include

sources:
  - rtl/CpuPkg.sv
  - rtl/CpuIfs.sv
  - rtl/MainDecoder.sv
  - rtl/RegFile.sv
  - rtl/Alu.sv
  - rtl/InstructionMemory.sv
  - rtl/DataMemory.sv
  - rtl/NextPcUnit.sv
  - rtl/SingleCycleCpu.sv
  - target: simulation
    files:
      - verif/SingleCycleCpuTb.sv

// File: verif/cpu_tests.txt
# T name cycleBound starts a test
# P instruction then optionally R reg data or M address data, all in hex
# writes are expected in the order listed, skipped instructions list none
T alu_ops 16
P 20010007 R 1 00000007
P 2002FFFD R 2 FFFFFFFD
P 00221820 R 3 00000004
P 00412022 R 4 FFFFFFF6
P 00222824 R 5 00000005
P 00223025 R 6 FFFFFFFF
P 0041382A R 7 00000001
P 0022402A R 8 00000000
P 08000008
T addi_sign 8
P 20017FFF R 1 00007FFF
P 20228000 R 2 FFFFFFFF
P 08000002
T store_load 12
P 20010010 R 1 00000010
P 2002FB2E R 2 FFFFFB2E
P AC220008 M 00000018 FFFFFB2E
P 8C230008 R 3 FFFFFB2E
P AC21FFFC M 0000000C 00000010
P 8C04000C R 4 00000010
P 08000006
T branches 14
P 20010003 R 1 00000003
P 20020003 R 2 00000003
P 10220001
P 20030001
P 14220001
P 20040002 R 4 00000002
P 14200001
P 20050005
P 10200001
P 20060006 R 6 00000006
P 0800000A
T jumps 10
P 20010018 R 1 00000018
P 08000004
P 20020009
P 20030009
P 00200008
P 20040009
P 20050005 R 5 00000005
P 08000007
T zero_reg 8
P 20000005
P 20010004 R 1 00000004
P 00011020 R 2 00000004
P 08000003
T reset_clears 8
P 00221820 R 3 00000000
P 8C040018 R 4 00000000
P 08000002

// File: verif/SingleCycleCpuTb.sv
`default_nettype none

`include "cpu_config.svh"

module SingleCycleCpuTb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int ResetCycles = 10;
    // reset and load overhead allowed per test
    localparam int LoadSlack = 20;

    logic                             clk;
    logic                             reset;
    logic                             loadEnable;
    logic [`CPU_IMEM_INDEX_WIDTH-1:0] loadAddress;
    logic [`CPU_DATA_WIDTH-1:0]       loadData;
    logic [`CPU_DATA_WIDTH-1:0]       instruction;
    logic [`CPU_DATA_WIDTH-1:0]       pcOut;
    logic                             regWriteValid;
    logic [`CPU_REG_INDEX_WIDTH-1:0]  regWriteIndex;
    logic [`CPU_DATA_WIDTH-1:0]       regWriteData;
    logic                             memWriteValid;
    logic [`CPU_DATA_WIDTH-1:0]       memWriteAddress;
    logic [`CPU_DATA_WIDTH-1:0]       memWriteData;

    // parsed test file
    string                      testName [$];
    int                         testBound [$];
    int                         progStart [$];
    int                         evStart [$];
    logic [`CPU_DATA_WIDTH-1:0] progWords [$];
    string                      evKind [$];
    logic [`CPU_DATA_WIDTH-1:0] evFirst [$];
    logic [`CPU_DATA_WIDTH-1:0] evSecond [$];

    int    errorCount;
    int    testErrors;
    int    passCount;
    int    failCount;
    int    cycleCount;
    int    cycleLimit;
    string currentTest;

    SingleCycleCpu dut (
        .clk(clk),
        .reset(reset),
        .loadEnable(loadEnable),
        .loadAddress(loadAddress),
        .loadData(loadData),
        .instruction(instruction),
        .pcOut(pcOut),
        .regWriteValid(regWriteValid),
        .regWriteIndex(regWriteIndex),
        .regWriteData(regWriteData),
        .memWriteValid(memWriteValid),
        .memWriteAddress(memWriteAddress),
        .memWriteData(memWriteData)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycleCount++;
        if (cycleLimit > 0 && cycleCount >= cycleLimit) begin
            $display("timeout after %0d cycles, the run did not finish", cycleCount);
            $display("Some tests failed");
            $finish;
        end
    end

    task automatic reportProblem(input string msg);
        $display("%s: %s", currentTest, msg);
        testErrors++;
    endtask

    task automatic compareRegWrite(
        input logic [`CPU_REG_INDEX_WIDTH-1:0] expIndex,
        input logic [`CPU_DATA_WIDTH-1:0]      expData,
        input logic [`CPU_REG_INDEX_WIDTH-1:0] actIndex,
        input logic [`CPU_DATA_WIDTH-1:0]      actData
    );
        if (actIndex !== expIndex || actData !== expData) begin
            $display("error: %s register write expected r%0d = %h, actual r%0d = %h",
                     currentTest, expIndex, expData, actIndex, actData);
            testErrors++;
        end
    endtask

    task automatic compareMemWrite(
        input logic [`CPU_DATA_WIDTH-1:0] expAddress,
        input logic [`CPU_DATA_WIDTH-1:0] expData,
        input logic [`CPU_DATA_WIDTH-1:0] actAddress,
        input logic [`CPU_DATA_WIDTH-1:0] actData
    );
        if (actAddress !== expAddress || actData !== expData) begin
            $display("error: %s memory write expected [%h] = %h, actual [%h] = %h",
                     currentTest, expAddress, expData, actAddress, actData);
            testErrors++;
        end
    endtask

    task automatic compareFetch(
        input logic [`CPU_DATA_WIDTH-1:0] expPc,
        input logic [`CPU_DATA_WIDTH-1:0] expInstruction,
        input logic [`CPU_DATA_WIDTH-1:0] actPc,
        input logic [`CPU_DATA_WIDTH-1:0] actInstruction
    );
        if (actPc !== expPc || actInstruction !== expInstruction) begin
            $display("error: %s final fetch expected pc %h = %h, actual pc %h = %h",
                     currentTest, expPc, expInstruction, actPc, actInstruction);
            testErrors++;
        end
    endtask

    task automatic readTests();
        int                         fd;
        int                         n;
        int                         bound;
        string                      line;
        string                      tag;
        string                      name;
        string                      kind;
        logic [`CPU_DATA_WIDTH-1:0] word;
        logic [`CPU_DATA_WIDTH-1:0] first;
        logic [`CPU_DATA_WIDTH-1:0] second;
        fd = $fopen("verif/cpu_tests.txt", "r");
        if (fd == 0) begin
            $display("the test file verif/cpu_tests.txt could not be opened");
            errorCount++;
            return;
        end
        while ($fgets(line, fd) != 0) begin
            n = $sscanf(line, "%s", tag);
            if (n == 1 && tag.substr(0, 0) != "#") begin
                if (tag == "T") begin
                    n = $sscanf(line, "%s %s %d", tag, name, bound);
                    testName.push_back(name);
                    testBound.push_back(bound);
                    progStart.push_back(progWords.size());
                    evStart.push_back(evKind.size());
                end else if (tag == "P" && testName.size() > 0) begin
                    n = $sscanf(line, "%s %h %s %h %h", tag, word, kind, first, second);
                    progWords.push_back(word);
                    if (n == 5) begin
                        evKind.push_back(kind);
                        evFirst.push_back(first);
                        evSecond.push_back(second);
                    end
                end else begin
                    $display("the test file has a line that cannot be read: %s", line);
                    errorCount++;
                end
            end
        end
        $fclose(fd);
    endtask

    // reset held at least ResetCycles, program words loaded meanwhile
    task automatic loadProgram(input int t);
        int first;
        int count;
        int c;
        first = progStart[t];
        count = ((t + 1 < testName.size()) ? progStart[t + 1] : progWords.size()) - first;
        @(negedge clk);
        reset = 1'b1;
        for (c = 0; c < ResetCycles || c < count; c++) begin
            if (c < count) begin
                loadEnable = 1'b1;
                loadAddress = c;
                loadData = progWords[first + c];
            end else begin
                loadEnable = 1'b0;
            end
            @(negedge clk);
        end
        loadEnable = 1'b0;
        reset = 1'b0;
    endtask

    // one trace sample per cycle, taken mid low phase
    task automatic runProgram(input int t);
        int                         nextEv;
        int                         lastEv;
        int                         cycles;
        int                         progFirst;
        int                         progCount;
        bit                         finished;
        logic [`CPU_DATA_WIDTH-1:0] lastPc;
        nextEv = evStart[t];
        lastEv = (t + 1 < testName.size()) ? evStart[t + 1] : evKind.size();
        progFirst = progStart[t];
        progCount = (t + 1 < testName.size()) ? progStart[t + 1] : progWords.size();
        progCount = progCount - progFirst;
        cycles = 0;
        finished = 1'b0;
        lastPc = '0;
        while (!finished && cycles < testBound[t]) begin
            #2;
            if (regWriteValid === 1'b1) begin
                if (nextEv < lastEv && evKind[nextEv] == "R") begin
                    compareRegWrite(evFirst[nextEv][`CPU_REG_INDEX_WIDTH-1:0],
                                    evSecond[nextEv], regWriteIndex, regWriteData);
                    nextEv++;
                end else begin
                    reportProblem($sformatf("unexpected register write r%0d = %h at pc %h",
                                            regWriteIndex, regWriteData, pcOut));
                end
            end
            if (memWriteValid === 1'b1) begin
                if (nextEv < lastEv && evKind[nextEv] == "M") begin
                    compareMemWrite(evFirst[nextEv], evSecond[nextEv],
                                    memWriteAddress, memWriteData);
                    nextEv++;
                end else begin
                    reportProblem($sformatf("unexpected memory write [%h] = %h at pc %h",
                                            memWriteAddress, memWriteData, pcOut));
                end
            end
            // pc unchanged over a cycle means the self jump ran
            if (cycles > 0 && pcOut === lastPc) begin
                finished = 1'b1;
                // the self jump is the last word of every program
                compareFetch((progCount - 1) * 4, progWords[progFirst + progCount - 1],
                             pcOut, instruction);
            end
            lastPc = pcOut;
            cycles++;
            @(negedge clk);
        end
        if (!finished) begin
            reportProblem($sformatf("program did not reach its self jump in %0d cycles",
                                    testBound[t]));
        end
        while (nextEv < lastEv) begin
            reportProblem($sformatf("expected %s write %h = %h never happened",
                                    evKind[nextEv], evFirst[nextEv], evSecond[nextEv]));
            nextEv++;
        end
    endtask

    initial begin
        int t;
        int boundSum;
        clk = 1'b0;
        reset = 1'b1;
        loadEnable = 1'b0;
        loadAddress = '0;
        loadData = '0;
        errorCount = 0;
        passCount = 0;
        failCount = 0;
        cycleCount = 0;
        cycleLimit = 0;
        readTests();
        boundSum = 0;
        foreach (testBound[i]) begin
            boundSum += testBound[i] + LoadSlack;
        end
        cycleLimit = boundSum + LoadSlack;
        if (testName.size() == 0) begin
            $display("no tests were read from the test file");
            errorCount++;
        end
        for (t = 0; t < testName.size(); t++) begin
            currentTest = testName[t];
            testErrors = 0;
            loadProgram(t);
            runProgram(t);
            if (testErrors == 0) begin
                $display("test %s passed", currentTest);
                passCount++;
            end else begin
                $display("test %s failed with %0d errors", currentTest, testErrors);
                failCount++;
                errorCount += testErrors;
            end
        end
        $display("%0d tests run, %0d passed, %0d failed", testName.size(), passCount, failCount);
        if (errorCount == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: rtl/SingleCycleCpu.sv
`default_nettype none

`include "cpu_config.svh"

module SingleCycleCpu import CpuPkg::*; (
    input  wire                                 clk,
    input  wire                                 reset,
    input  logic                                loadEnable,
    input  logic [`CPU_IMEM_INDEX_WIDTH-1:0]    loadAddress,
    input  logic [`CPU_DATA_WIDTH-1:0]          loadData,
    output logic [`CPU_DATA_WIDTH-1:0]          instruction,
    output logic [`CPU_DATA_WIDTH-1:0]          pcOut,
    output logic                                regWriteValid,
    output logic [`CPU_REG_INDEX_WIDTH-1:0]     regWriteIndex,
    output logic [`CPU_DATA_WIDTH-1:0]          regWriteData,
    output logic                                memWriteValid,
    output logic [`CPU_DATA_WIDTH-1:0]          memWriteAddress,
    output logic [`CPU_DATA_WIDTH-1:0]          memWriteData
);

    ctrlSignalsT                     ctrl;
    logic [`CPU_DATA_WIDTH-1:0]      extendedImmediate;
    logic [`CPU_DATA_WIDTH-1:0]      aluSourceB;
    logic [`CPU_DATA_WIDTH-1:0]      aluResult;
    logic                            isAluResultZero;
    logic [`CPU_REG_INDEX_WIDTH-1:0] writeRegister;
    logic [`CPU_DATA_WIDTH-1:0]      writeBackData;

    regPortIf regPort();
    dataMemIf dataMem();

    // fetch, program load is only honoured while held in reset
    InstructionMemory instructionMemory (
        .clk(clk),
        .loadEnable(loadEnable & reset),
        .loadAddress(loadAddress),
        .loadData(loadData),
        .readAddress(pcOut),
        .data(instruction)
    );

    MainDecoder control (
        .opcode(opcodeE'(instruction[31:26])),
        .funct(functE'(instruction[5:0])),
        .ctrl(ctrl)
    );

    assign extendedImmediate = {{16{instruction[15]}}, instruction[15:0]};
    // rd for r-type, rt otherwise
    assign writeRegister = ctrl.regDst ? instruction[15:11] : instruction[20:16];

    assign regPort.readRegister1 = instruction[25:21];
    assign regPort.readRegister2 = instruction[20:16];
    assign regPort.writeRegister = writeRegister;
    assign regPort.writeData     = writeBackData;
    assign regPort.writeEnable   = regWriteValid;

    RegFile registers (
        .clk(clk),
        .reset(reset),
        .port(regPort)
    );

    assign aluSourceB = ctrl.aluSrc ? extendedImmediate : regPort.readData2;

    Alu alu (
        .aluOp(ctrl.aluOp),
        .leftOperand(regPort.readData1),
        .rightOperand(aluSourceB),
        .aluResult(aluResult),
        .zero(isAluResultZero)
    );

    assign dataMem.address     = aluResult;
    assign dataMem.writeData   = regPort.readData2;
    assign dataMem.readEnable  = ctrl.memRead;
    assign dataMem.writeEnable = memWriteValid;

    DataMemory dataMemory (
        .clk(clk),
        .reset(reset),
        .port(dataMem)
    );

    assign writeBackData = ctrl.memtoReg ? dataMem.readData : aluResult;

    NextPcUnit nextPcUnit (
        .clk(clk),
        .reset(reset),
        .ctrl(ctrl),
        .zero(isAluResultZero),
        .immediate(extendedImmediate),
        .target(instruction[25:0]),
        .jumpRegisterAddress(regPort.readData1),
        .pcOut(pcOut)
    );

    // qualified writes, nothing retires during reset and r0 is never written
    assign regWriteValid = ctrl.regWrite & (writeRegister != '0) & ~reset;
    assign memWriteValid = ctrl.memWrite & ~reset;

    // retirement trace
    assign regWriteIndex   = writeRegister;
    assign regWriteData    = writeBackData;
    assign memWriteAddress = aluResult;
    assign memWriteData    = regPort.readData2;

endmodule

`default_nettype wire

// File: rtl/NextPcUnit.sv
`default_nettype none

`include "cpu_config.svh"

module NextPcUnit import CpuPkg::*; (
    input  wire                        clk,
    input  wire                        reset,
    input  ctrlSignalsT                ctrl,
    input  logic                       zero,
    input  logic [`CPU_DATA_WIDTH-1:0] immediate,
    input  logic [25:0]                target,
    input  logic [`CPU_DATA_WIDTH-1:0] jumpRegisterAddress,
    output logic [`CPU_DATA_WIDTH-1:0] pcOut
);

    logic [`CPU_DATA_WIDTH-1:0] pcPlusFour;
    logic [`CPU_DATA_WIDTH-1:0] branchTarget;
    logic [`CPU_DATA_WIDTH-1:0] jumpTarget;
    logic [`CPU_DATA_WIDTH-1:0] nextPc;
    logic                       branchTaken;

    assign pcPlusFour   = pcOut + 32'd4;
    assign branchTarget = pcPlusFour + (immediate << 2);
    // region bits come from pc+4
    assign jumpTarget   = {pcPlusFour[31:28], target, 2'b00};
    assign branchTaken  = (ctrl.branch & zero) | (ctrl.branchNe & ~zero);

    always_comb begin
        if (ctrl.jumpRegister) begin
            nextPc = jumpRegisterAddress;
        end else if (ctrl.jump) begin
            nextPc = jumpTarget;
        end else if (branchTaken) begin
            nextPc = branchTarget;
        end else begin
            nextPc = pcPlusFour;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pcOut <= '0;
        end else begin
            pcOut <= nextPc;
        end
    end

endmodule

`default_nettype wire

// File: rtl/DataMemory.sv
`default_nettype none

`include "cpu_config.svh"

module DataMemory (
    input wire    clk,
    input wire    reset,
    dataMemIf.mem port
);

    localparam int IndexWidth = `CPU_DMEM_INDEX_WIDTH;

    logic [`CPU_DATA_WIDTH-1:0] words [`CPU_DMEM_WORDS];
    logic [IndexWidth-1:0]      wordIndex;

    assign wordIndex = port.address[IndexWidth+1:2];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `CPU_DMEM_WORDS; i++) begin
                words[i] <= '0;
            end
        end else if (port.writeEnable) begin
            words[wordIndex] <= port.writeData;
        end
    end

    // reads as zero unless a load is in progress
    assign port.readData = port.readEnable ? words[wordIndex] : '0;

endmodule

`default_nettype wire

// File: rtl/InstructionMemory.sv
`default_nettype none

`include "cpu_config.svh"

module InstructionMemory (
    input  wire                                 clk,
    input  logic                                loadEnable,
    input  logic [`CPU_IMEM_INDEX_WIDTH-1:0]    loadAddress,
    input  logic [`CPU_DATA_WIDTH-1:0]          loadData,
    input  logic [`CPU_DATA_WIDTH-1:0]          readAddress,
    output logic [`CPU_DATA_WIDTH-1:0]          data
);

    localparam int IndexWidth = `CPU_IMEM_INDEX_WIDTH;

    logic [`CPU_DATA_WIDTH-1:0] words [`CPU_IMEM_WORDS];

    // program load path only
    always_ff @(posedge clk) begin
        if (loadEnable) begin
            words[loadAddress] <= loadData;
        end
    end

    // byte address to word index
    assign data = words[readAddress[IndexWidth+1:2]];

endmodule

`default_nettype wire

// File: rtl/Alu.sv
`default_nettype none

`include "cpu_config.svh"

module Alu import CpuPkg::*; (
    input  aluOpE                      aluOp,
    input  logic [`CPU_DATA_WIDTH-1:0] leftOperand,
    input  logic [`CPU_DATA_WIDTH-1:0] rightOperand,
    output logic [`CPU_DATA_WIDTH-1:0] aluResult,
    output logic                       zero
);

    logic signed [`CPU_DATA_WIDTH-1:0] leftSigned;
    logic signed [`CPU_DATA_WIDTH-1:0] rightSigned;

    assign leftSigned  = leftOperand;
    assign rightSigned = rightOperand;

    always_comb begin
        case (aluOp)
            ALU_ADD: aluResult = leftSigned + rightSigned;
            ALU_SUB: aluResult = leftSigned - rightSigned;
            ALU_AND: aluResult = leftOperand & rightOperand;
            ALU_OR:  aluResult = leftOperand | rightOperand;
            // signed compare, result is 0 or 1
            ALU_SLT: begin
                aluResult = '0;
                aluResult[0] = leftSigned < rightSigned;
            end
            default: aluResult = '0;
        endcase
    end

    // beq and bne look at this after a subtract
    assign zero = (aluResult == '0);

endmodule

`default_nettype wire

// File: rtl/RegFile.sv
`default_nettype none

`include "cpu_config.svh"

module RegFile (
    input wire   clk,
    input wire   reset,
    regPortIf.mem port
);

    localparam int NumRegs = 1 << `CPU_REG_INDEX_WIDTH;

    // r0 has no storage
    logic [`CPU_DATA_WIDTH-1:0] regs [1:NumRegs-1];

    // caller guarantees writeRegister is nonzero when writeEnable is high
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 1; i < NumRegs; i++) begin
                regs[i] <= '0;
            end
        end else if (port.writeEnable) begin
            regs[port.writeRegister] <= port.writeData;
        end
    end

    always_comb begin
        if (port.readRegister1 == '0) begin
            port.readData1 = '0;
        end else begin
            port.readData1 = regs[port.readRegister1];
        end
        if (port.readRegister2 == '0) begin
            port.readData2 = '0;
        end else begin
            port.readData2 = regs[port.readRegister2];
        end
    end

endmodule

`default_nettype wire

// File: rtl/MainDecoder.sv
`default_nettype none

module MainDecoder import CpuPkg::*; (
    input  opcodeE      opcode,
    input  functE       funct,
    output ctrlSignalsT ctrl
);

    always_comb begin
        // everything inactive unless the opcode is recognised
        ctrl = '0;
        ctrl.aluOp = ALU_ADD;
        case (opcode)
            RTYPE: begin
                ctrl.regDst = 1'b1;
                case (funct)
                    ADD: begin
                        ctrl.regWrite = 1'b1;
                        ctrl.aluOp = ALU_ADD;
                    end
                    SUB: begin
                        ctrl.regWrite = 1'b1;
                        ctrl.aluOp = ALU_SUB;
                    end
                    AND: begin
                        ctrl.regWrite = 1'b1;
                        ctrl.aluOp = ALU_AND;
                    end
                    OR: begin
                        ctrl.regWrite = 1'b1;
                        ctrl.aluOp = ALU_OR;
                    end
                    SLT: begin
                        ctrl.regWrite = 1'b1;
                        ctrl.aluOp = ALU_SLT;
                    end
                    JR: ctrl.jumpRegister = 1'b1;
                    // unknown funct falls through as a no-op
                    default: ctrl.regDst = 1'b0;
                endcase
            end
            ADDI: begin
                ctrl.aluSrc = 1'b1;
                ctrl.regWrite = 1'b1;
            end
            LW: begin
                ctrl.aluSrc = 1'b1;
                ctrl.memRead = 1'b1;
                ctrl.memtoReg = 1'b1;
                ctrl.regWrite = 1'b1;
            end
            SW: begin
                ctrl.aluSrc = 1'b1;
                ctrl.memWrite = 1'b1;
            end
            BEQ: begin
                ctrl.branch = 1'b1;
                ctrl.aluOp = ALU_SUB;
            end
            BNE: begin
                ctrl.branchNe = 1'b1;
                ctrl.aluOp = ALU_SUB;
            end
            J: ctrl.jump = 1'b1;
            default: ctrl = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: rtl/CpuIfs.sv
`default_nettype none

`include "cpu_config.svh"

// register file access, two reads and one write
interface regPortIf;
    logic [`CPU_REG_INDEX_WIDTH-1:0] readRegister1;
    logic [`CPU_REG_INDEX_WIDTH-1:0] readRegister2;
    logic [`CPU_DATA_WIDTH-1:0]      readData1;
    logic [`CPU_DATA_WIDTH-1:0]      readData2;
    logic [`CPU_REG_INDEX_WIDTH-1:0] writeRegister;
    logic [`CPU_DATA_WIDTH-1:0]      writeData;
    logic                            writeEnable;

    modport cpu (
        output readRegister1, readRegister2, writeRegister, writeData, writeEnable,
        input  readData1, readData2
    );
    modport mem (
        input  readRegister1, readRegister2, writeRegister, writeData, writeEnable,
        output readData1, readData2
    );
endinterface

// data memory access, byte address with word granularity
interface dataMemIf;
    logic [`CPU_DATA_WIDTH-1:0] address;
    logic [`CPU_DATA_WIDTH-1:0] writeData;
    logic                       readEnable;
    logic                       writeEnable;
    logic [`CPU_DATA_WIDTH-1:0] readData;

    modport cpu (output address, writeData, readEnable, writeEnable, input readData);
    modport mem (input address, writeData, readEnable, writeEnable, output readData);
endinterface

`default_nettype wire

// File: rtl/CpuPkg.sv
`default_nettype none

package CpuPkg;

    // primary opcode field, instruction[31:26]
    typedef enum logic [5:0] {
        RTYPE = 6'h00,
        J     = 6'h02,
        BEQ   = 6'h04,
        BNE   = 6'h05,
        ADDI  = 6'h08,
        LW    = 6'h23,
        SW    = 6'h2b
    } opcodeE;

    // r-type function field, instruction[5:0]
    typedef enum logic [5:0] {
        JR  = 6'h08,
        ADD = 6'h20,
        SUB = 6'h22,
        AND = 6'h24,
        OR  = 6'h25,
        SLT = 6'h2a
    } functE;

    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_SLT = 3'd4
    } aluOpE;

    // decoded control for one instruction
    typedef struct packed {
        logic  regDst;
        logic  aluSrc;
        logic  memRead;
        logic  memWrite;
        logic  memtoReg;
        logic  regWrite;
        logic  branch;
        logic  branchNe;
        logic  jump;
        logic  jumpRegister;
        aluOpE aluOp;
    } ctrlSignalsT;

endpackage

`default_nettype wire

// File: include/cpu_config.svh
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// datapath word width
`define CPU_DATA_WIDTH 32

// memory depths in words
`define CPU_IMEM_WORDS 64
`define CPU_DMEM_WORDS 64

// word index widths derived from the depths
`define CPU_IMEM_INDEX_WIDTH $clog2(`CPU_IMEM_WORDS)
`define CPU_DMEM_INDEX_WIDTH $clog2(`CPU_DMEM_WORDS)

// register file index width
`define CPU_REG_INDEX_WIDTH 5

`endif
